//--- flist.f
+incdir+rtl
rtl/tag_pkg.sv
rtl/tag_master.sv
rtl/tag_client.sv
rtl/chip_config_regs.sv
rtl/chip_config_top.sv
test/tb_chip_config.sv

//--- rtl/chip_config_regs.sv
`timescale 1ns/1ps
`include "tag_defines.svh"

module chip_config_regs
  import tag_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  tag_line_s [`TAG_NUM_CLIENTS-1:0]  tag_lines_i,
  output node_tag_s                         core_o,
  output node_tag_s                         host_o,
  output node_tag_s                         router_o,
  output dmc_ctrl_s                         dmc_ctrl_o,
  output dmc_timing_s                       dmc_timing_o,
  output tag_client_mask_t                  config_update_o
);

  ////////////////////
  // Node clients
  ////////////////////

  node_tag_s [`TAG_ID_ROUTER:`TAG_ID_CORE] node_data;

  // Core, host and router share one payload layout
  for (genvar i = `TAG_ID_CORE; i <= `TAG_ID_ROUTER; i++)
  begin : g_node
    tag_client #(.WIDTH($bits(node_tag_s))) node_client_i (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .tag_line_i (tag_lines_i[i]),
      .data_o     (node_data[i]),
      .new_o      (config_update_o[i])
    );
  end

  assign core_o   = node_data[`TAG_ID_CORE];
  assign host_o   = node_data[`TAG_ID_HOST];
  assign router_o = node_data[`TAG_ID_ROUTER];

  ////////////////////
  // DRAM clients
  ////////////////////

  tag_client #(.WIDTH($bits(dmc_ctrl_s))) dmc_ctrl_client_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .tag_line_i (tag_lines_i[`TAG_ID_DMC_CTRL]),
    .data_o     (dmc_ctrl_o),
    .new_o      (config_update_o[`TAG_ID_DMC_CTRL])
  );

  dmc_param_t [`DMC_NUM_PARAMS-1:0] param_data;

  // Parameter bytes occupy the ids after the control byte
  for (genvar i = 0; i < `DMC_NUM_PARAMS; i++)
  begin : g_param
    tag_client #(.WIDTH(`DMC_PARAM_WIDTH)) param_client_i (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .tag_line_i (tag_lines_i[`TAG_ID_DMC_PARAM + i]),
      .data_o     (param_data[i]),
      .new_o      (config_update_o[`TAG_ID_DMC_PARAM + i])
    );
  end

  // Refresh interval spans two bytes, low byte first
  assign dmc_timing_o.trefi        = {param_data[1], param_data[0]};

  // Nibble fields, low nibble of each byte first
  assign dmc_timing_o.tmrd         = param_data[2][3:0];
  assign dmc_timing_o.trfc         = param_data[2][7:4];
  assign dmc_timing_o.trc          = param_data[3][3:0];
  assign dmc_timing_o.trp          = param_data[3][7:4];
  assign dmc_timing_o.tras         = param_data[4][3:0];
  assign dmc_timing_o.trrd         = param_data[4][7:4];
  assign dmc_timing_o.trcd         = param_data[5][3:0];
  assign dmc_timing_o.twr          = param_data[5][7:4];
  assign dmc_timing_o.twtr         = param_data[6][3:0];
  assign dmc_timing_o.trtp         = param_data[6][7:4];
  assign dmc_timing_o.tcas         = param_data[7][3:0];
  assign dmc_timing_o.col_width    = param_data[7][7:4];
  assign dmc_timing_o.row_width    = param_data[8][3:0];
  assign dmc_timing_o.init_cmd_cnt = param_data[8][7:4];

  // Last byte carries two 2-bit fields, upper nibble spare
  assign dmc_timing_o.bank_width   = param_data[9][1:0];
  assign dmc_timing_o.dqs_sel_cal  = param_data[9][3:2];

endmodule

//--- rtl/chip_config_top.sv
`timescale 1ns/1ps
`include "tag_defines.svh"

module chip_config_top
  import tag_pkg::*;
(
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             tag_data_i,
  input  logic             tag_en_i,
  output node_tag_s        core_o,
  output node_tag_s        host_o,
  output node_tag_s        router_o,
  output dmc_ctrl_s        dmc_ctrl_o,
  output dmc_timing_s      dmc_timing_o,
  output tag_client_mask_t config_update_o
);

  // All client lines from the master
  tag_line_s [`TAG_NUM_CLIENTS-1:0] tag_lines;

  // Serial packet decoder
  tag_master tag_master_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .tag_data_i  (tag_data_i),
    .tag_en_i    (tag_en_i),
    .tag_lines_o (tag_lines)
  );

  // Client registers and config unpacking
  chip_config_regs chip_config_regs_i (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .tag_lines_i     (tag_lines),
    .core_o          (core_o),
    .host_o          (host_o),
    .router_o        (router_o),
    .dmc_ctrl_o      (dmc_ctrl_o),
    .dmc_timing_o    (dmc_timing_o),
    .config_update_o (config_update_o)
  );

endmodule

//--- rtl/tag_client.sv
`timescale 1ns/1ps

module tag_client
  import tag_pkg::*;
#(
  parameter int WIDTH = 8
)
(
  input  logic             clk_i,
  input  logic             reset_i,
  input  tag_line_s        tag_line_i,
  output logic [WIDTH-1:0] data_o,
  output logic             new_o
);

  logic [WIDTH-1:0] shift_r;
  logic [WIDTH-1:0] data_r;
  logic             new_r;

  // Bits enter at the msb end
  // After WIDTH shifts the first bit sits at bit 0
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      shift_r <= '0;
    end
    else if (tag_line_i.shift)
    begin
      shift_r <= {tag_line_i.data, shift_r[WIDTH-1:1]};
    end
  end

  // Committed copy plus a one cycle update flag
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      data_r <= '0;
      new_r  <= 1'b0;
    end
    else
    begin
      new_r <= tag_line_i.commit;
      if (tag_line_i.commit)
      begin
        data_r <= shift_r;
      end
    end
  end

  assign data_o = data_r;
  assign new_o  = new_r;

endmodule

//--- rtl/tag_defines.svh
`ifndef TAG_DEFINES_SVH
`define TAG_DEFINES_SVH

// Packet header field widths
`define TAG_ID_WIDTH     4
`define TAG_LEN_WIDTH    4

// Number of tag clients on the master
`define TAG_NUM_CLIENTS  14

// Fixed client ids
`define TAG_ID_CORE      0
`define TAG_ID_HOST      1
`define TAG_ID_ROUTER    2
`define TAG_ID_DMC_CTRL  3
`define TAG_ID_DMC_PARAM 4

// Payload field widths
`define NODE_DID_WIDTH   3
`define DMC_NUM_PARAMS   10
`define DMC_PARAM_WIDTH  8

`endif

//--- rtl/tag_master.sv
`timescale 1ns/1ps
`include "tag_defines.svh"

module tag_master
  import tag_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              tag_data_i,
  input  logic                              tag_en_i,
  output tag_line_s [`TAG_NUM_CLIENTS-1:0]  tag_lines_o
);

  // Stream bit, forced low while the enable is off
  logic bit_in;
  assign bit_in = tag_en_i & tag_data_i;

  tag_state_e state_r;
  tag_id_t    id_r;
  tag_len_t   len_r;
  tag_len_t   cnt_r;
  logic       accept_r;
  logic       commit_r;

  tag_line_s [`TAG_NUM_CLIENTS-1:0] lines_n;
  tag_line_s [`TAG_NUM_CLIENTS-1:0] lines_r;

  // Header fields arrive lsb first, so shift in from the top
  tag_id_t  id_next;
  tag_len_t len_next;
  assign id_next  = {bit_in, id_r[`TAG_ID_WIDTH-1:1]};
  assign len_next = {bit_in, len_r[`TAG_LEN_WIDTH-1:1]};

  // Length must match the width of an existing client
  // Ids 14 and 15 never match
  logic len_ok;
  always_comb
  begin
    len_ok = 1'b0;
    for (int i = 0; i < `TAG_NUM_CLIENTS; i++)
    begin
      if ((id_r == tag_id_t'(i)) && (len_next == tag_client_width[i]))
      begin
        len_ok = 1'b1;
      end
    end
  end

  ////////////////////
  // Packet FSM
  ////////////////////

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r  <= e_idle;
      id_r     <= '0;
      len_r    <= '0;
      cnt_r    <= '0;
      accept_r <= 1'b0;
      commit_r <= 1'b0;
    end
    else
    begin
      // Commit is a one cycle strobe
      commit_r <= 1'b0;
      case (state_r)
        e_idle:
        begin
          // Start bit opens a packet
          if (bit_in)
          begin
            state_r <= e_id;
            cnt_r   <= '0;
          end
        end
        e_id:
        begin
          id_r  <= id_next;
          cnt_r <= cnt_r + 1'b1;
          if (cnt_r == tag_len_t'(`TAG_ID_WIDTH-1))
          begin
            state_r <= e_len;
            cnt_r   <= '0;
          end
        end
        e_len:
        begin
          len_r <= len_next;
          cnt_r <= cnt_r + 1'b1;
          if (cnt_r == tag_len_t'(`TAG_LEN_WIDTH-1))
          begin
            // Decide once per packet whether its payload goes anywhere
            accept_r <= len_ok;
            cnt_r    <= len_next - 1'b1;
            if (len_next == '0)
            begin
              state_r <= e_idle;
            end
            else
            begin
              state_r <= e_payload;
            end
          end
        end
        e_payload:
        begin
          // Count remaining bits down to the last one
          cnt_r <= cnt_r - 1'b1;
          if (cnt_r == '0)
          begin
            state_r  <= e_idle;
            commit_r <= accept_r;
          end
        end
        default:
        begin
          state_r <= e_idle;
        end
      endcase
    end
  end

  ////////////////////
  // Line drive
  ////////////////////

  // Only the addressed client of an accepted packet sees activity
  // id_r is still stable during the commit cycle
  always_comb
  begin
    for (int i = 0; i < `TAG_NUM_CLIENTS; i++)
    begin
      lines_n[i].shift  = accept_r && (id_r == tag_id_t'(i)) && (state_r == e_payload);
      lines_n[i].data   = lines_n[i].shift && bit_in;
      lines_n[i].commit = accept_r && (id_r == tag_id_t'(i)) && commit_r;
    end
  end

  // Registered lines, one cycle after the sampled stream bit
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      lines_r <= '0;
    end
    else
    begin
      lines_r <= lines_n;
    end
  end

  assign tag_lines_o = lines_r;

endmodule

//--- rtl/tag_pkg.sv
`include "tag_defines.svh"

package tag_pkg;

  // Header fields of a tag packet
  typedef logic [`TAG_ID_WIDTH-1:0]  tag_id_t;
  typedef logic [`TAG_LEN_WIDTH-1:0] tag_len_t;

  // Destination id for core, host and router
  typedef logic [`NODE_DID_WIDTH-1:0] did_t;

  typedef struct packed {
    logic reset;
    did_t did;
  } node_tag_s;

  // DRAM controller control byte
  typedef struct packed {
    logic       reset;
    logic [5:0] pad;
    logic       bypass;
  } dmc_ctrl_s;

  typedef logic [`DMC_PARAM_WIDTH-1:0] dmc_param_t;

  // Timing record built from the ten parameter bytes
  typedef struct packed {
    logic [2*`DMC_PARAM_WIDTH-1:0] trefi;
    logic [`DMC_PARAM_WIDTH/2-1:0] tmrd;
    logic [`DMC_PARAM_WIDTH/2-1:0] trfc;
    logic [`DMC_PARAM_WIDTH/2-1:0] trc;
    logic [`DMC_PARAM_WIDTH/2-1:0] trp;
    logic [`DMC_PARAM_WIDTH/2-1:0] tras;
    logic [`DMC_PARAM_WIDTH/2-1:0] trrd;
    logic [`DMC_PARAM_WIDTH/2-1:0] trcd;
    logic [`DMC_PARAM_WIDTH/2-1:0] twr;
    logic [`DMC_PARAM_WIDTH/2-1:0] twtr;
    logic [`DMC_PARAM_WIDTH/2-1:0] trtp;
    logic [`DMC_PARAM_WIDTH/2-1:0] tcas;
    logic [`DMC_PARAM_WIDTH/2-1:0] col_width;
    logic [`DMC_PARAM_WIDTH/2-1:0] row_width;
    logic [`DMC_PARAM_WIDTH/2-1:0] init_cmd_cnt;
    logic [1:0]                    bank_width;
    logic [1:0]                    dqs_sel_cal;
  } dmc_timing_s;

  // One line per client, driven by the master
  typedef struct packed {
    logic shift;
    logic data;
    logic commit;
  } tag_line_s;

  typedef logic [`TAG_NUM_CLIENTS-1:0] tag_client_mask_t;

  typedef enum logic [1:0] {e_idle, e_id, e_len, e_payload} tag_state_e;

  // Payload width per client id
  localparam tag_len_t tag_client_width [`TAG_NUM_CLIENTS] = '{
    4'd4, 4'd4, 4'd4,
    4'd8,
    4'd8, 4'd8, 4'd8, 4'd8, 4'd8,
    4'd8, 4'd8, 4'd8, 4'd8, 4'd8
  };

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the tag configuration testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_chip_config -f flist.f \
  && ./obj_dir/Vtb_chip_config 2>&1 | tee sim.log \
  || { echo "build or run error"; exit 1; }
# Verdict from the log
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0

//--- test/tb_chip_config.sv
`timescale 1ns/1ps
`include "tag_defines.svh"

module tb_chip_config
  import tag_pkg::*;
();

  // Run length and cycle budget
  localparam int NUM_PACKETS   = 200;
  localparam int RESET_CYCLES  = 10;
  localparam int GAP_CYCLES    = 4;
  localparam int MAX_PAYLOAD   = 8;
  localparam int MAX_PKT_CYCLES = 1 + `TAG_ID_WIDTH + `TAG_LEN_WIDTH + MAX_PAYLOAD + GAP_CYCLES;
  localparam int CYCLE_MARGIN  = 790;
  localparam int CYCLE_LIMIT   = RESET_CYCLES + NUM_PACKETS * MAX_PKT_CYCLES + CYCLE_MARGIN;

  logic             clk_i;
  logic             reset_i;
  logic             tag_data_i;
  logic             tag_en_i;
  node_tag_s        core_o;
  node_tag_s        host_o;
  node_tag_s        router_o;
  dmc_ctrl_s        dmc_ctrl_o;
  dmc_timing_s      dmc_timing_o;
  tag_client_mask_t config_update_o;

  // Expected contents of every client register
  dmc_param_t       exp_val [`TAG_NUM_CLIENTS];
  tag_client_mask_t exp_upd;
  tag_client_mask_t upd_seen;
  int               seed = 71;
  int               pkt_count;
  int               cycles;
  string            cur_test;

  chip_config_top chip_config_top_i (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .tag_data_i      (tag_data_i),
    .tag_en_i        (tag_en_i),
    .core_o          (core_o),
    .host_o          (host_o),
    .router_o        (router_o),
    .dmc_ctrl_o      (dmc_ctrl_o),
    .dmc_timing_o    (dmc_timing_o),
    .config_update_o (config_update_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic fail_stop(string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "run stopped at first error");
  endtask

  function automatic int rand_below(int n);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return r % n;
  endfunction

  // Payload width per id
  // Ids with no client give zero
  function automatic int client_width(int id);
    if (id < 3)
    begin
      return 4;
    end
    else if (id < 14)
    begin
      return 8;
    end
    return 0;
  endfunction

  // Expected timing record from the param bytes at ids 4 to 13
  function automatic dmc_timing_s expected_timing();
    dmc_timing_s t;
    t.trefi        = {exp_val[5], exp_val[4]};
    t.tmrd         = exp_val[6][3:0];
    t.trfc         = exp_val[6][7:4];
    t.trc          = exp_val[7][3:0];
    t.trp          = exp_val[7][7:4];
    t.tras         = exp_val[8][3:0];
    t.trrd         = exp_val[8][7:4];
    t.trcd         = exp_val[9][3:0];
    t.twr          = exp_val[9][7:4];
    t.twtr         = exp_val[10][3:0];
    t.trtp         = exp_val[10][7:4];
    t.tcas         = exp_val[11][3:0];
    t.col_width    = exp_val[11][7:4];
    t.row_width    = exp_val[12][3:0];
    t.init_cmd_cnt = exp_val[12][7:4];
    t.bank_width   = exp_val[13][1:0];
    t.dqs_sel_cal  = exp_val[13][3:2];
    return t;
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_node(string name, node_tag_s exp_v, node_tag_s act_v);
    if (exp_v !== act_v)
    begin
      fail_stop($sformatf("mismatch %s expected %h actual %h", name, exp_v, act_v));
    end
  endtask

  task automatic check_dmc_ctrl(string name, dmc_ctrl_s exp_v, dmc_ctrl_s act_v);
    if (exp_v !== act_v)
    begin
      fail_stop($sformatf("mismatch %s expected %h actual %h", name, exp_v, act_v));
    end
  endtask

  task automatic check_dmc_timing(string name, dmc_timing_s exp_v, dmc_timing_s act_v);
    if (exp_v !== act_v)
    begin
      fail_stop($sformatf("mismatch %s expected %h actual %h", name, exp_v, act_v));
    end
  endtask

  task automatic check_update(string name, tag_client_mask_t exp_v, tag_client_mask_t act_v);
    if (exp_v !== act_v)
    begin
      fail_stop($sformatf("mismatch %s expected %h actual %h", name, exp_v, act_v));
    end
  endtask

  task automatic check_outputs(tag_client_mask_t upd_exp);
    check_node({cur_test, " core"}, node_tag_s'(exp_val[0][3:0]), core_o);
    check_node({cur_test, " host"}, node_tag_s'(exp_val[1][3:0]), host_o);
    check_node({cur_test, " router"}, node_tag_s'(exp_val[2][3:0]), router_o);
    check_dmc_ctrl({cur_test, " dmc ctrl"}, dmc_ctrl_s'(exp_val[3]), dmc_ctrl_o);
    check_dmc_timing({cur_test, " dmc timing"}, expected_timing(), dmc_timing_o);
    check_update({cur_test, " update"}, upd_exp, upd_seen);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  // One stream bit per falling edge
  // Update pulses are collected before the new bit goes out
  task automatic send_bit(logic d, logic en);
    @(negedge clk_i);
    upd_seen   = upd_seen | config_update_o;
    tag_data_i = d;
    tag_en_i   = en;
  endtask

  // Idle bits read as zero by data or by enable
  task automatic idle_cycles(int n);
    logic en;
    for (int i = 0; i < n; i++)
    begin
      en = (rand_below(2) == 1);
      send_bit(en ? 1'b0 : (rand_below(2) == 1), en);
    end
  endtask

  // Header always goes out enabled
  // Enable may drop during the payload
  task automatic send_packet(int id, int len, dmc_param_t payload);
    logic       drop;
    logic       en;
    dmc_param_t gated;
    drop  = (rand_below(4) == 0);
    gated = '0;
    cur_test = {cur_test, $sformatf(" pkt %0d id %0d len %0d", pkt_count, id, len)};
    send_bit(1'b1, 1'b1);
    for (int i = 0; i < `TAG_ID_WIDTH; i++)
    begin
      send_bit(id[i], 1'b1);
    end
    for (int i = 0; i < `TAG_LEN_WIDTH; i++)
    begin
      send_bit(len[i], 1'b1);
    end
    for (int i = 0; i < len; i++)
    begin
      en = drop ? (rand_below(2) == 1) : 1'b1;
      gated[i] = payload[i] & en;
      send_bit(en ? payload[i] : (rand_below(2) == 1), en);
    end
    // Model acceptance rule
    if ((id < `TAG_NUM_CLIENTS) && (len == client_width(id)))
    begin
      exp_val[id] = gated;
      exp_upd[id] = 1'b1;
    end
    pkt_count++;
  endtask

  task automatic send_valid();
    int id;
    id = rand_below(`TAG_NUM_CLIENTS);
    send_packet(id, client_width(id), 8'(rand_below(256)));
  endtask

  task automatic send_wrong_len();
    int id;
    int len;
    id  = rand_below(`TAG_NUM_CLIENTS);
    len = rand_below(MAX_PAYLOAD + 1);
    while (len == client_width(id))
    begin
      len = rand_below(MAX_PAYLOAD + 1);
    end
    send_packet(id, len, 8'(rand_below(256)));
  endtask

  // Ids 14 and 15 address nothing
  task automatic send_bad_id();
    send_packet(14 + rand_below(2), rand_below(MAX_PAYLOAD + 1), 8'(rand_below(256)));
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial
  begin
    int kind;
    reset_i    = 1'b1;
    tag_data_i = 1'b0;
    tag_en_i   = 1'b0;
    pkt_count  = 0;
    upd_seen   = '0;
    exp_upd    = '0;
    for (int i = 0; i < `TAG_NUM_CLIENTS; i++)
    begin
      exp_val[i] = '0;
    end
    repeat (RESET_CYCLES) @(negedge clk_i);
    reset_i  = 1'b0;
    cur_test = "reset";
    // Live update bits right after reset
    upd_seen = config_update_o;
    check_outputs('0);
    while (pkt_count < NUM_PACKETS)
    begin
      upd_seen = '0;
      exp_upd  = '0;
      cur_test = "window";
      kind     = rand_below(8);
      if (kind < 4)
      begin
        send_valid();
      end
      else if (kind == 4)
      begin
        send_wrong_len();
      end
      else if (kind == 5)
      begin
        send_bad_id();
      end
      else if (pkt_count <= NUM_PACKETS - 2)
      begin
        // Back to back packets with no idle between them
        send_valid();
        send_valid();
      end
      else
      begin
        send_valid();
      end
      idle_cycles(GAP_CYCLES);
      check_outputs(exp_upd);
    end
    $display("Test passed");
    $finish;
  end

  // Watchdog on total run length
  initial
  begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT)
    begin
      @(posedge clk_i);
      cycles++;
    end
    fail_stop($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
  end

endmodule
